//--- source/afu_pkg.sv
package afu_pkg;

  localparam int LINE_W      = 64;
  localparam int ADDR_W      = 32;
  localparam int TAG_W       = 16;
  localparam int MMIO_ADDR_W = 16;
  localparam int MMIO_TID_W  = 9;
  localparam int CMD_W       = 3;

  localparam logic [MMIO_ADDR_W-1:0] MMIO_DFH      = 16'h0000;
  localparam logic [MMIO_ADDR_W-1:0] MMIO_ID_L     = 16'h0002;
  localparam logic [MMIO_ADDR_W-1:0] MMIO_ID_H     = 16'h0004;
  localparam logic [MMIO_ADDR_W-1:0] MMIO_CMD_TYPE = 16'h000A;
  localparam logic [MMIO_ADDR_W-1:0] MMIO_CMD_ARG0 = 16'h000C;
  localparam logic [MMIO_ADDR_W-1:0] MMIO_CMD_ARG1 = 16'h000E;
  localparam logic [MMIO_ADDR_W-1:0] MMIO_CMD_ARG2 = 16'h0010;
  localparam logic [MMIO_ADDR_W-1:0] MMIO_STATUS   = 16'h0012;

  // AFU feature type, end of DFH list, no next offset
  localparam logic [63:0] DFH_VALUE = {4'b0001, 19'b0, 1'b1, 40'b0};
  localparam logic [127:0] AFU_ID = 128'h3a7c_51e0_9d24_4b8f_a612_07c5_e93d_2f48;

  localparam logic [CMD_W-1:0] CMD_MEM_READ  = 3'd1;  // Local to host
  localparam logic [CMD_W-1:0] CMD_MEM_WRITE = 3'd2;  // Host to local

  typedef enum logic [1:0] {
    ST_IDLE      = 2'd0,
    ST_MEM_WRITE = 2'd1,
    ST_MEM_READ  = 2'd2
  } state_t;

  localparam int RD_WINDOW      = 8;
  localparam int RD_TAG_W       = $clog2(RD_WINDOW);
  localparam int RD_PENDING_MAX = 16;
  localparam int WR_PENDING_MAX = 256;

  typedef struct packed {
    logic                   rd_valid;
    logic                   wr_valid;
    logic [MMIO_ADDR_W-1:0] addr;
    logic [MMIO_TID_W-1:0]  tid;
    logic [LINE_W-1:0]      data;
  } mmio_req_t;

  typedef struct packed {
    logic                  valid;
    logic [MMIO_TID_W-1:0] tid;
    logic [LINE_W-1:0]     data;
  } mmio_rsp_t;

  typedef struct packed {
    logic [ADDR_W-1:0] io_addr;
    logic [ADDR_W-1:0] mem_addr;
    logic [ADDR_W-1:0] size;
  } cmd_t;

  typedef struct packed {
    logic                valid;
    logic [ADDR_W-1:0]   addr;
    logic [RD_TAG_W-1:0] tag;
  } host_rd_req_t;

  typedef struct packed {
    logic                valid;
    logic [RD_TAG_W-1:0] tag;
    logic [LINE_W-1:0]   data;
  } host_rd_rsp_t;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
    logic [LINE_W-1:0] data;
  } host_wr_req_t;

  typedef struct packed {
    logic              rw;  // 1 = write
    logic [ADDR_W-1:0] addr;
    logic [LINE_W-1:0] data;
    logic [TAG_W-1:0]  tag;
  } mem_req_t;

  typedef struct packed {
    logic [LINE_W-1:0] data;
    logic [TAG_W-1:0]  tag;
  } mem_rsp_t;

  typedef struct packed {
    logic              read;
    logic              write;
    logic [ADDR_W-1:0] address;
    logic [LINE_W-1:0] writedata;
  } bank_out_t;

  typedef struct packed {
    logic              waitrequest;
    logic              readdatavalid;
    logic [LINE_W-1:0] readdata;
  } bank_in_t;

endpackage

//--- source/line_fifo.sv
`timescale 1ns/100ps

module line_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     push,
  input  logic     pop,
  input  payload_t din,
  output payload_t dout,
  output logic     empty,
  output logic     full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t                   mem [DEPTH];
  logic [PTR_W-1:0]           wr_ptr;
  logic [PTR_W-1:0]           rd_ptr;
  logic [CNT_W-1:0]           count;
  logic                       do_push;
  logic                       do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign empty   = (count == 0);
  assign full    = (count == CNT_W'(DEPTH));
  assign dout    = mem[rd_ptr];

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= next_ptr(wr_ptr);
      if (do_pop) rd_ptr <= next_ptr(rd_ptr);
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= din;
  end

endmodule

//--- source/mmio_regs.sv
`timescale 1ns/100ps

module mmio_regs import afu_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  input  mmio_req_t        mmio_req,
  input  state_t           state,
  output mmio_rsp_t        mmio_rsp,
  output cmd_t             cmd,
  output logic             cmd_start,
  output logic [CMD_W-1:0] cmd_code
);

  logic                  rsp_valid;
  logic [MMIO_TID_W-1:0] rsp_tid;
  logic [LINE_W-1:0]     rsp_data;
  logic                  is_cmd_wr;

  assign is_cmd_wr = mmio_req.wr_valid && (mmio_req.addr == MMIO_CMD_TYPE);
  assign mmio_rsp  = '{valid: rsp_valid, tid: rsp_tid, data: rsp_data};

  always_ff @(posedge clk) begin
    if (reset) begin
      rsp_valid <= 1'b0;
      cmd_start <= 1'b0;
    end else begin
      rsp_valid <= mmio_req.rd_valid;  // One cycle read latency
      cmd_start <= is_cmd_wr;
    end
  end

  always_ff @(posedge clk) begin
    rsp_tid <= mmio_req.tid;
    case (mmio_req.addr)
      MMIO_DFH:    rsp_data <= DFH_VALUE;
      MMIO_ID_L:   rsp_data <= AFU_ID[63:0];
      MMIO_ID_H:   rsp_data <= AFU_ID[127:64];
      MMIO_STATUS: rsp_data <= LINE_W'(state);
      default:     rsp_data <= '0;
    endcase

    if (is_cmd_wr) cmd_code <= mmio_req.data[CMD_W-1:0];

    // Arguments frozen while a copy runs
    if (mmio_req.wr_valid && (state == ST_IDLE)) begin
      case (mmio_req.addr)
        MMIO_CMD_ARG0: cmd.io_addr  <= mmio_req.data[ADDR_W-1:0];
        MMIO_CMD_ARG1: cmd.mem_addr <= mmio_req.data[ADDR_W-1:0];
        MMIO_CMD_ARG2: cmd.size     <= mmio_req.data[ADDR_W-1:0];
        default: ;
      endcase
    end
  end

endmodule

//--- source/cmd_fsm.sv
`timescale 1ns/100ps

module cmd_fsm import afu_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  input  logic             cmd_start,
  input  logic [CMD_W-1:0] cmd_code,
  input  logic             wr_done,
  input  logic             rd_done,
  output state_t           state
);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (cmd_start) begin
            if (cmd_code == CMD_MEM_WRITE) begin
              state <= ST_MEM_WRITE;
            end else if (cmd_code == CMD_MEM_READ) begin
              state <= ST_MEM_READ;
            end
          end
        end
        ST_MEM_WRITE: if (wr_done) state <= ST_IDLE;  // Host to local finished
        ST_MEM_READ:  if (rd_done) state <= ST_IDLE;
        default:      state <= ST_IDLE;
      endcase
    end
  end

endmodule

//--- source/host_rd_engine.sv
`timescale 1ns/100ps

module host_rd_engine import afu_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  state_t       state,
  input  cmd_t         cmd,
  output host_rd_req_t host_rd_req,
  input  host_rd_rsp_t host_rd_rsp,
  input  logic         host_rd_alm_full,
  output mem_req_t     mem_req,
  output logic         mem_req_valid,
  input  logic         mem_req_ready,
  output logic         done
);

  typedef struct packed {
    logic [LINE_W-1:0] data;
    logic [ADDR_W-1:0] addr;
  } rdq_entry_t;

  localparam int PEND_W = $clog2(RD_PENDING_MAX + 1);

  logic                busy;
  logic                start;
  logic [ADDR_W-1:0]   req_ctr;
  logic [ADDR_W-1:0]   wr_ctr;
  logic [ADDR_W-1:0]   addr_base;
  logic [RD_TAG_W-1:0] req_tag;
  logic [RD_TAG_W-1:0] rsp_ctr;
  logic [PEND_W-1:0]   pending;
  logic                win_wait;
  logic                req_fire;
  logic                wr_fire;
  logic                q_empty;
  rdq_entry_t          q_din;
  rdq_entry_t          q_dout;

  assign start   = (state == ST_MEM_WRITE) && !busy;
  assign req_tag = req_ctr[RD_TAG_W-1:0];

  // No ready on the host channel, valid is the fire
  assign req_fire = busy && (req_ctr != cmd.size) && !win_wait && !host_rd_alm_full
                 && (pending != PEND_W'(RD_PENDING_MAX));
  assign host_rd_req = '{valid: req_fire, addr: cmd.io_addr + req_ctr, tag: req_tag};

  // Responses land in the queue already placed by tag
  assign q_din = '{data: host_rd_rsp.data, addr: addr_base + ADDR_W'(host_rd_rsp.tag)};

  assign mem_req_valid = !q_empty;
  assign mem_req = '{rw: 1'b1, addr: q_dout.addr, data: q_dout.data, tag: wr_ctr[TAG_W-1:0]};
  assign wr_fire = mem_req_valid && mem_req_ready;
  assign done    = busy && (wr_ctr == cmd.size);

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
    end else begin
      busy <= (state == ST_MEM_WRITE);
    end
  end

  always_ff @(posedge clk) begin
    if (reset || start) begin
      req_ctr   <= '0;
      rsp_ctr   <= '0;
      wr_ctr    <= '0;
      pending   <= '0;
      win_wait  <= 1'b0;
      addr_base <= cmd.mem_addr;
    end else begin
      if (req_fire) req_ctr <= req_ctr + 1'b1;
      if (wr_fire) wr_ctr <= wr_ctr + 1'b1;
      pending <= pending + PEND_W'(req_fire) - PEND_W'(wr_fire);

      if (req_fire && (req_tag == RD_TAG_W'(RD_WINDOW - 1))) begin
        win_wait <= 1'b1;  // Window issued, wait for all of it
      end
      if (host_rd_rsp.valid) begin
        rsp_ctr <= rsp_ctr + 1'b1;
        if (rsp_ctr == RD_TAG_W'(RD_WINDOW - 1)) begin
          win_wait  <= 1'b0;
          addr_base <= addr_base + ADDR_W'(RD_WINDOW);
        end
      end
    end
  end

  line_fifo #(
    .payload_t (rdq_entry_t),
    .DEPTH     (RD_PENDING_MAX)
  ) rd_queue (
    .clk   (clk),
    .reset (reset),
    .push  (host_rd_rsp.valid),
    .pop   (wr_fire),
    .din   (q_din),
    .dout  (q_dout),
    .empty (q_empty),
    .full  ()
  );

endmodule

//--- source/host_wr_engine.sv
`timescale 1ns/100ps

module host_wr_engine import afu_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  state_t       state,
  input  cmd_t         cmd,
  output mem_req_t     mem_req,
  output logic         mem_req_valid,
  input  logic         mem_req_ready,
  input  mem_rsp_t     mem_rsp,
  input  logic         mem_rsp_valid,
  output logic         mem_rsp_ready,
  output host_wr_req_t host_wr_req,
  input  logic         host_wr_rsp,
  input  logic         host_wr_alm_full,
  output logic         done
);

  localparam int PEND_W = $clog2(WR_PENDING_MAX + 1);

  logic              busy;
  logic              start;
  logic              rd_fire;
  logic              rsp_fire;
  logic              wr_valid;
  logic [ADDR_W-1:0] rd_ctr;
  logic [ADDR_W-1:0] wr_ctr;
  logic [ADDR_W-1:0] wr_addr;
  logic [LINE_W-1:0] wr_data;
  logic [PEND_W-1:0] pending;

  assign start = (state == ST_MEM_READ) && !busy;

  // Line index doubles as the read tag
  assign mem_req_valid = busy && (rd_ctr != cmd.size);
  assign mem_req = '{rw: 1'b0, addr: cmd.mem_addr + rd_ctr, data: '0, tag: rd_ctr[TAG_W-1:0]};
  assign rd_fire = mem_req_valid && mem_req_ready;

  assign mem_rsp_ready = !host_wr_alm_full && (pending != PEND_W'(WR_PENDING_MAX));
  assign rsp_fire      = mem_rsp_valid && mem_rsp_ready;

  assign host_wr_req = '{valid: wr_valid, addr: wr_addr, data: wr_data};
  assign done        = busy && (wr_ctr == cmd.size) && (pending == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      busy     <= 1'b0;
      wr_valid <= 1'b0;
    end else begin
      busy     <= (state == ST_MEM_READ);
      wr_valid <= rsp_fire;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || start) begin
      rd_ctr  <= '0;
      wr_ctr  <= '0;
      pending <= '0;
    end else begin
      if (rd_fire) rd_ctr <= rd_ctr + 1'b1;
      if (wr_valid) wr_ctr <= wr_ctr + 1'b1;
      pending <= pending + PEND_W'(rsp_fire) - PEND_W'(host_wr_rsp);  // Until acked
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_fire) begin
      wr_addr <= cmd.io_addr + ADDR_W'(mem_rsp.tag);
      wr_data <= mem_rsp.data;
    end
  end

endmodule

//--- source/bank_router.sv
`timescale 1ns/100ps

module bank_router import afu_pkg::*; #(
  parameter int NUM_BANKS = 2
) (
  input  mem_req_t             wr_req,
  input  logic                 wr_req_valid,
  output logic                 wr_req_ready,
  input  mem_req_t             rd_req,
  input  logic                 rd_req_valid,
  output logic                 rd_req_ready,
  output mem_req_t             bank_req [NUM_BANKS],
  output logic [NUM_BANKS-1:0] bank_req_valid,
  input  logic [NUM_BANKS-1:0] bank_req_ready
);

  localparam int SEL_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

  mem_req_t         sel_req;
  logic             sel_valid;
  logic [SEL_W-1:0] bank;

  assign sel_req   = wr_req_valid ? wr_req : rd_req;  // Write source first
  assign sel_valid = wr_req_valid || rd_req_valid;
  assign bank      = SEL_W'(sel_req.addr % NUM_BANKS);

  assign wr_req_ready = bank_req_ready[bank];
  assign rd_req_ready = !wr_req_valid && bank_req_ready[bank];

  always_comb begin
    for (int i = 0; i < NUM_BANKS; i++) begin
      bank_req[i]       = sel_req;
      bank_req[i].addr  = ADDR_W'(sel_req.addr / NUM_BANKS);
      bank_req_valid[i] = sel_valid && (bank == SEL_W'(i));
    end
  end

endmodule

//--- source/bank_ctrl.sv
`timescale 1ns/100ps

module bank_ctrl import afu_pkg::*; #(
  parameter int RD_QUEUE_SIZE = 4
) (
  input  logic      clk,
  input  logic      reset,
  input  mem_req_t  req,
  input  logic      req_valid,
  output logic      req_ready,
  output bank_out_t bank_out,
  input  bank_in_t  bank_in,
  output mem_rsp_t  rsp,
  output logic      rsp_valid,
  input  logic      rsp_ready
);

  localparam int CNT_W = $clog2(RD_QUEUE_SIZE + 1);

  logic [CNT_W-1:0] outstanding;
  logic             rd_room;
  logic             rd_fire;
  logic             rsp_pop;
  logic             rsp_empty;
  logic [TAG_W-1:0] tag_head;
  mem_rsp_t         rsp_din;

  // Reads in flight plus responses not yet taken
  assign rd_room = (outstanding != CNT_W'(RD_QUEUE_SIZE));

  assign bank_out = '{
    read:      req_valid && !req.rw && rd_room,
    write:     req_valid && req.rw,
    address:   req.addr,
    writedata: req.data
  };
  assign req_ready = !bank_in.waitrequest && (req.rw || rd_room);
  assign rd_fire   = bank_out.read && !bank_in.waitrequest;

  assign rsp_din   = '{data: bank_in.readdata, tag: tag_head};
  assign rsp_valid = !rsp_empty;
  assign rsp_pop   = rsp_valid && rsp_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      outstanding <= '0;
    end else begin
      outstanding <= outstanding + CNT_W'(rd_fire) - CNT_W'(rsp_pop);
    end
  end

  line_fifo #(
    .payload_t (logic [TAG_W-1:0]),
    .DEPTH     (RD_QUEUE_SIZE)
  ) tag_queue (
    .clk   (clk),
    .reset (reset),
    .push  (rd_fire),
    .pop   (bank_in.readdatavalid),
    .din   (req.tag),
    .dout  (tag_head),
    .empty (),
    .full  ()
  );

  line_fifo #(
    .payload_t (mem_rsp_t),
    .DEPTH     (RD_QUEUE_SIZE)
  ) rsp_queue (
    .clk   (clk),
    .reset (reset),
    .push  (bank_in.readdatavalid),
    .pop   (rsp_pop),
    .din   (rsp_din),
    .dout  (rsp),
    .empty (rsp_empty),
    .full  ()
  );

endmodule

//--- source/rsp_merge.sv
`timescale 1ns/100ps

module rsp_merge import afu_pkg::*; #(
  parameter int NUM_BANKS = 2
) (
  input  mem_rsp_t             bank_rsp [NUM_BANKS],
  input  logic [NUM_BANKS-1:0] bank_rsp_valid,
  output logic [NUM_BANKS-1:0] bank_rsp_ready,
  output mem_rsp_t             rsp,
  output logic                 rsp_valid,
  input  logic                 rsp_ready
);

  assign rsp_valid = |bank_rsp_valid;

  // Lowest valid bank wins, scanned from the top down
  always_comb begin
    rsp            = bank_rsp[0];
    bank_rsp_ready = '0;
    for (int i = NUM_BANKS - 1; i >= 0; i--) begin
      if (bank_rsp_valid[i]) begin
        rsp               = bank_rsp[i];
        bank_rsp_ready    = '0;
        bank_rsp_ready[i] = rsp_ready;
      end
    end
  end

endmodule

//--- source/afu_top.sv
`timescale 1ns/100ps

module afu_top import afu_pkg::*; #(
  parameter int NUM_BANKS     = 2,
  parameter int RD_QUEUE_SIZE = 4
) (
  input  logic         clk,
  input  logic         reset,
  input  mmio_req_t    mmio_req,
  output mmio_rsp_t    mmio_rsp,
  output host_rd_req_t host_rd_req,
  input  host_rd_rsp_t host_rd_rsp,
  input  logic         host_rd_alm_full,
  output host_wr_req_t host_wr_req,
  input  logic         host_wr_rsp,
  input  logic         host_wr_alm_full,
  output bank_out_t    bank_out [NUM_BANKS],
  input  bank_in_t     bank_in [NUM_BANKS]
);

  state_t               state;
  cmd_t                 cmd;
  logic                 cmd_start;
  logic [CMD_W-1:0]     cmd_code;
  logic                 wr_done;
  logic                 rd_done;
  mem_req_t             lmem_wr_req;
  logic                 lmem_wr_valid;
  logic                 lmem_wr_ready;
  mem_req_t             lmem_rd_req;
  logic                 lmem_rd_valid;
  logic                 lmem_rd_ready;
  mem_req_t             bank_req [NUM_BANKS];
  logic [NUM_BANKS-1:0] bank_req_valid;
  logic [NUM_BANKS-1:0] bank_req_ready;
  mem_rsp_t             bank_rsp [NUM_BANKS];
  logic [NUM_BANKS-1:0] bank_rsp_valid;
  logic [NUM_BANKS-1:0] bank_rsp_ready;
  mem_rsp_t             lmem_rsp;
  logic                 lmem_rsp_valid;
  logic                 lmem_rsp_ready;

  mmio_regs mmio_regs_i (
    .clk       (clk),
    .reset     (reset),
    .mmio_req  (mmio_req),
    .state     (state),
    .mmio_rsp  (mmio_rsp),
    .cmd       (cmd),
    .cmd_start (cmd_start),
    .cmd_code  (cmd_code)
  );

  cmd_fsm cmd_fsm_i (
    .clk       (clk),
    .reset     (reset),
    .cmd_start (cmd_start),
    .cmd_code  (cmd_code),
    .wr_done   (wr_done),
    .rd_done   (rd_done),
    .state     (state)
  );

  // Host to local
  host_rd_engine host_rd_engine_i (
    .clk              (clk),
    .reset            (reset),
    .state            (state),
    .cmd              (cmd),
    .host_rd_req      (host_rd_req),
    .host_rd_rsp      (host_rd_rsp),
    .host_rd_alm_full (host_rd_alm_full),
    .mem_req          (lmem_wr_req),
    .mem_req_valid    (lmem_wr_valid),
    .mem_req_ready    (lmem_wr_ready),
    .done             (wr_done)
  );

  // Local to host
  host_wr_engine host_wr_engine_i (
    .clk              (clk),
    .reset            (reset),
    .state            (state),
    .cmd              (cmd),
    .mem_req          (lmem_rd_req),
    .mem_req_valid    (lmem_rd_valid),
    .mem_req_ready    (lmem_rd_ready),
    .mem_rsp          (lmem_rsp),
    .mem_rsp_valid    (lmem_rsp_valid),
    .mem_rsp_ready    (lmem_rsp_ready),
    .host_wr_req      (host_wr_req),
    .host_wr_rsp      (host_wr_rsp),
    .host_wr_alm_full (host_wr_alm_full),
    .done             (rd_done)
  );

  bank_router #(
    .NUM_BANKS (NUM_BANKS)
  ) bank_router_i (
    .wr_req         (lmem_wr_req),
    .wr_req_valid   (lmem_wr_valid),
    .wr_req_ready   (lmem_wr_ready),
    .rd_req         (lmem_rd_req),
    .rd_req_valid   (lmem_rd_valid),
    .rd_req_ready   (lmem_rd_ready),
    .bank_req       (bank_req),
    .bank_req_valid (bank_req_valid),
    .bank_req_ready (bank_req_ready)
  );

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    bank_ctrl #(
      .RD_QUEUE_SIZE (RD_QUEUE_SIZE)
    ) bank_ctrl_i (
      .clk       (clk),
      .reset     (reset),
      .req       (bank_req[b]),
      .req_valid (bank_req_valid[b]),
      .req_ready (bank_req_ready[b]),
      .bank_out  (bank_out[b]),
      .bank_in   (bank_in[b]),
      .rsp       (bank_rsp[b]),
      .rsp_valid (bank_rsp_valid[b]),
      .rsp_ready (bank_rsp_ready[b])
    );
  end

  rsp_merge #(
    .NUM_BANKS (NUM_BANKS)
  ) rsp_merge_i (
    .bank_rsp       (bank_rsp),
    .bank_rsp_valid (bank_rsp_valid),
    .bank_rsp_ready (bank_rsp_ready),
    .rsp            (lmem_rsp),
    .rsp_valid      (lmem_rsp_valid),
    .rsp_ready      (lmem_rsp_ready)
  );

endmodule

//--- bench/tb_mem_models.sv
`timescale 1ns/100ps

// Host memory, read responses shuffled within the current window
module tb_host_mem import afu_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic [31:0]       rnd,
  input  host_rd_req_t      rd_req,
  output host_rd_rsp_t      rd_rsp,
  output logic [ADDR_W-1:0] lookup_addr,
  input  logic [LINE_W-1:0] lookup_data,
  input  host_wr_req_t      wr_req,
  output logic              wr_rsp
);

  logic [LINE_W-1:0]    data_q [RD_WINDOW];
  logic [RD_WINDOW-1:0] held;
  logic [RD_WINDOW-1:0] clr;
  logic [RD_WINDOW-1:0] set;
  logic [RD_TAG_W-1:0]  pick;
  logic                 ack;
  int                   wr_unacked;

  assign lookup_addr = rd_req.addr;
  assign pick        = rnd[RD_TAG_W-1:0];

  initial begin
    rd_rsp = '0;
    wr_rsp = 1'b0;
  end

  always @(posedge clk) begin
    if (reset) begin
      held       <= '0;
      rd_rsp     <= '0;
      wr_rsp     <= 1'b0;
      wr_unacked <= 0;
    end else begin
      clr = '0;
      set = '0;
      rd_rsp.valid <= 1'b0;
      if (held[pick] && rnd[8]) begin
        rd_rsp    <= '{valid: 1'b1, tag: pick, data: data_q[pick]};
        clr[pick] = 1'b1;
      end
      if (rd_req.valid) begin
        data_q[rd_req.tag] <= lookup_data;
        set[rd_req.tag] = 1'b1;
      end
      held <= (held & ~clr) | set;

      ack = (wr_unacked != 0) && rnd[12];  // Acks trickle back
      wr_rsp     <= ack;
      wr_unacked <= wr_unacked + int'(wr_req.valid) - int'(ack);
    end
  end

endmodule

module tb_local_bank import afu_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] rnd,
  input  logic        stress,
  input  bank_out_t   bank_out,
  output bank_in_t    bank_in
);

  logic [LINE_W-1:0] mem [1024];
  logic [LINE_W-1:0] rdq [$];

  initial bank_in = '0;

  always @(posedge clk) begin
    if (reset) begin
      bank_in <= '0;
      rdq.delete();
    end else begin
      if (bank_out.write && !bank_in.waitrequest) mem[bank_out.address[9:0]] <= bank_out.writedata;
      if (bank_out.read && !bank_in.waitrequest) rdq.push_back(mem[bank_out.address[9:0]]);
      bank_in.waitrequest   <= stress && rnd[1];
      bank_in.readdatavalid <= 1'b0;
      if (rdq.size() != 0 && rnd[2]) begin  // Random read latency
        bank_in.readdatavalid <= 1'b1;
        bank_in.readdata      <= rdq.pop_front();
      end
    end
  end

endmodule

//--- bench/tb_afu.sv
`timescale 1ns/100ps

module tb_afu import afu_pkg::*;;

  localparam int NUM_BANKS = 2;
  localparam int SIZE      = 37;
  localparam logic [31:0] A = 32'h0000_2000;  // Host source
  localparam logic [31:0] B = 32'h0000_0100;  // Local lines
  localparam logic [31:0] C = 32'h0000_5000;  // Host destination

  logic         clk = 1'b0;
  logic         reset = 1'b1;
  logic [31:0]  rnd = 32'ha10fddc0;
  logic         stress = 1'b0;
  mmio_req_t    mmio_req = '0;
  mmio_rsp_t    mmio_rsp;
  host_rd_req_t host_rd_req;
  host_rd_rsp_t host_rd_rsp;
  logic         host_rd_alm_full = 1'b0;
  host_wr_req_t host_wr_req;
  logic         host_wr_rsp;
  logic         host_wr_alm_full = 1'b0;
  bank_out_t    bank_out [NUM_BANKS];
  bank_in_t     bank_in [NUM_BANKS];
  logic [31:0]  lookup_addr;
  logic [63:0]  wr_seen;
  logic [63:0]  hw_seen;
  int           rd_issued;
  int           rd_returned;
  int           bank_writes;
  int           host_writes;
  int           host_acks;
  int           cycle;

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // Initial host contents
  function automatic logic [63:0] line_pattern(input logic [31:0] addr);
    return {addr * 32'h9e37_79b1, addr ^ 32'hc3c3_0f0f};
  endfunction

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  afu_top #(.NUM_BANKS(NUM_BANKS), .RD_QUEUE_SIZE(4)) afu_top_i (
    .clk(clk), .reset(reset), .mmio_req(mmio_req), .mmio_rsp(mmio_rsp),
    .host_rd_req(host_rd_req), .host_rd_rsp(host_rd_rsp), .host_rd_alm_full(host_rd_alm_full),
    .host_wr_req(host_wr_req), .host_wr_rsp(host_wr_rsp), .host_wr_alm_full(host_wr_alm_full),
    .bank_out(bank_out), .bank_in(bank_in)
  );

  tb_host_mem host_mem_i (
    .clk(clk), .reset(reset), .rnd(rnd), .rd_req(host_rd_req), .rd_rsp(host_rd_rsp),
    .lookup_addr(lookup_addr), .lookup_data(line_pattern(lookup_addr)),
    .wr_req(host_wr_req), .wr_rsp(host_wr_rsp)
  );

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank_model
    tb_local_bank bank_i (
      .clk(clk), .reset(reset), .rnd(rnd >> (b * 5 + 7)), .stress(stress),
      .bank_out(bank_out[b]), .bank_in(bank_in[b])
    );
  end

  always @(posedge clk) begin
    rnd              <= xorshift(rnd);
    host_rd_alm_full <= stress && rnd[20];
    host_wr_alm_full <= stress && rnd[23];
  end

  // Protocol and data checker
  always @(posedge clk) begin
    int off;
    cycle <= cycle + 1;
    if (reset && cycle >= 2) begin
      check("reset host_rd_req.valid", 64'(0), 64'(host_rd_req.valid));
      check("reset host_wr_req.valid", 64'(0), 64'(host_wr_req.valid));
      for (int b = 0; b < NUM_BANKS; b++) begin
        check("reset bank access", 64'(0), 64'(bank_out[b].read || bank_out[b].write));
      end
    end
    if (!reset) begin
      if (host_rd_req.valid) begin
        check("host read while almost full", 64'(0), 64'(host_rd_alm_full));
        // Read but not yet written to local memory
        check("host reads outstanding", 64'(1), 64'(rd_issued - bank_writes < RD_PENDING_MAX));
        check("host read window", 64'(1),
              64'(rd_issued < (rd_returned / RD_WINDOW + 1) * RD_WINDOW));
        check("host read address", 64'(A + 32'(rd_issued)), 64'(host_rd_req.addr));
        check("host read tag", 64'(rd_issued % RD_WINDOW), 64'(host_rd_req.tag));
        rd_issued = rd_issued + 1;
      end
      if (host_rd_rsp.valid) rd_returned = rd_returned + 1;
      for (int b = 0; b < NUM_BANKS; b++) begin
        if (bank_out[b].write && !bank_in[b].waitrequest) begin
          off = int'(bank_out[b].address) * NUM_BANKS + b - int'(B);
          check("local write in range", 64'(1), 64'(off >= 0 && off < SIZE));
          check("local write duplicate", 64'(0), 64'(wr_seen[off]));
          check("host_to_local data", line_pattern(A + 32'(off)), bank_out[b].writedata);
          wr_seen[off] = 1'b1;
          bank_writes  = bank_writes + 1;
        end
      end
      if (host_wr_req.valid) begin
        off = int'(host_wr_req.addr - C);
        check("host write in range", 64'(1), 64'(off >= 0 && off < SIZE));
        check("host write duplicate", 64'(0), 64'(hw_seen[off]));
        check("local_to_host data", line_pattern(A + 32'(off)), host_wr_req.data);
        hw_seen[off] = 1'b1;
        host_writes  = host_writes + 1;
      end
      if (host_wr_rsp) host_acks = host_acks + 1;
    end
  end

  task automatic mmio_write(input logic [15:0] addr, input logic [63:0] data);
    @(posedge clk);
    mmio_req <= '{rd_valid: 1'b0, wr_valid: 1'b1, addr: addr, tid: '0, data: data};
    @(posedge clk);
    mmio_req <= '0;
  endtask

  task automatic mmio_read(input logic [15:0] addr, input logic [8:0] tid,
                           output logic [63:0] data);
    @(posedge clk);
    mmio_req <= '{rd_valid: 1'b1, wr_valid: 1'b0, addr: addr, tid: tid, data: '0};
    @(posedge clk);
    mmio_req <= '0;
    @(posedge clk);  // Response one cycle after capture
    check("mmio response valid", 64'(1), 64'(mmio_rsp.valid));
    check("mmio response tid", 64'(tid), 64'(mmio_rsp.tid));
    data = mmio_rsp.data;
  endtask

  task automatic wait_idle(input state_t busy_state);
    logic [63:0] status;
    forever begin
      mmio_read(MMIO_STATUS, 9'h055, status);
      if (status == 64'(0)) break;
      check("status while busy", 64'(busy_state), status);
    end
  endtask

  task automatic start_copy(input logic [31:0] io, input logic [CMD_W-1:0] code, input bit poke);
    wr_seen = '0;
    hw_seen = '0;
    bank_writes = 0;
    host_writes = 0;
    host_acks = 0;
    rd_issued = 0;
    rd_returned = 0;
    mmio_write(MMIO_CMD_ARG0, 64'(io));
    mmio_write(MMIO_CMD_ARG1, 64'(B));
    mmio_write(MMIO_CMD_ARG2, 64'(SIZE));
    mmio_write(MMIO_CMD_TYPE, 64'(code));
    if (poke) begin  // Commands during a copy
      mmio_write(MMIO_CMD_TYPE, 64'(CMD_MEM_READ + CMD_MEM_WRITE - code));
      mmio_write(MMIO_CMD_ARG2, 64'(5));
    end
  endtask

  task automatic copy_pair(input bit poke);
    start_copy(A, CMD_MEM_WRITE, poke);
    wait_idle(ST_MEM_WRITE);
    check("local writes", 64'(SIZE), 64'(bank_writes));
    start_copy(C, CMD_MEM_READ, poke);
    wait_idle(ST_MEM_READ);
    check("host writes", 64'(SIZE), 64'(host_writes));
    check("host write acks", 64'(SIZE), 64'(host_acks));
  endtask

  initial begin
    logic [63:0] data;
    cycle = 0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    mmio_read(MMIO_STATUS, 9'h001, data);
    check("status after reset", 64'(0), data);
    mmio_read(MMIO_DFH, 9'h102, data);
    check("dfh", DFH_VALUE, data);
    mmio_read(MMIO_ID_L, 9'h0a3, data);
    check("afu id low", AFU_ID[63:0], data);
    mmio_read(MMIO_ID_H, 9'h1f4, data);
    check("afu id high", AFU_ID[127:64], data);
    mmio_read(16'h0020, 9'h005, data);
    check("unused address", 64'(0), data);
    copy_pair(1'b0);
    stress <= 1'b1;
    copy_pair(1'b0);
    copy_pair(1'b1);
    $display("TESTBENCH PASSED");
    $finish;
  end

  // Six copies of SIZE lines at most
  initial begin
    repeat (300 * 6 * SIZE + 2000) @(posedge clk);
    $display("Watchdog timeout, the copies did not finish in time");
    $display("TESTBENCH FAILED");
    $fatal(1);
  end

endmodule

//--- tb.f
source/afu_pkg.sv
source/line_fifo.sv
source/mmio_regs.sv
source/cmd_fsm.sv
source/host_rd_engine.sv
source/host_wr_engine.sv
source/bank_router.sv
source/bank_ctrl.sv
source/rsp_merge.sv
source/afu_top.sv
bench/tb_mem_models.sv
bench/tb_afu.sv

//--- run.sh
#!/bin/sh
# Build and run the afu_top testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -f tb.f --top-module tb_afu -o sim_tb_afu &&
./obj_dir/sim_tb_afu | tee /dev/stderr | grep -q "TESTBENCH PASSED" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
